// ==== rtl/lc3b_settings.svh ====
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// flags come out of reset reading zero
`define LC3B_RESET_NZP 3'b010

`define LC3B_LINK_REG 3'd7

`define LC3B_TRAP_SHIFT 1

`endif

// ==== rtl/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

   typedef logic [15:0] lc3b_word;
   typedef logic [2:0]  lc3b_reg;
   typedef logic [2:0]  lc3b_nzp;
   typedef logic [3:0]  lc3b_imm4;
   typedef logic [7:0]  lc3b_trapvect8;

   typedef enum logic [3:0] {
      op_br   = 4'b0000,
      op_add  = 4'b0001,
      op_ldb  = 4'b0010,
      op_stb  = 4'b0011,
      op_jsr  = 4'b0100,
      op_and  = 4'b0101,
      op_ldr  = 4'b0110,
      op_str  = 4'b0111,
      op_rti  = 4'b1000,
      op_not  = 4'b1001,
      op_ldi  = 4'b1010,
      op_sti  = 4'b1011,
      op_jmp  = 4'b1100,
      op_shf  = 4'b1101,
      op_lea  = 4'b1110,
      op_trap = 4'b1111
   } lc3b_opcode;

   typedef enum logic [2:0] {
      alu_add,
      alu_and,
      alu_not,
      alu_pass,
      alu_sll,
      alu_srl,
      alu_sra
   } lc3b_aluop;

   typedef struct packed {
      lc3b_opcode opcode;
      lc3b_aluop  aluop;
      logic       load_cc;
      logic       load_pc;          // unconditional redirect
      logic       load_regfile;
      logic [2:0] alumux_sel;
      logic [1:0] pcmux_sel;
      logic       mem_read;
      logic       mem_write;
      logic       offsetmux_sel;    // offset11 instead of offset9
      logic       storemux_sel;     // sr2 port reads bits 11:9
      logic       destmux_sel;      // link register as dest
      logic [1:0] regfilemux_sel;
      logic [1:0] marmux_sel;
      logic [1:0] mdrmux_sel;
      logic       wordinmux_sel;    // byte load
      logic       offset6mux_sel;   // byte access, offset6 unscaled
      logic       valid_branch;
      logic       valid_dest;
      logic       alubasemux_sel;   // pc as alu base
      logic       predicted_branch;
   } lc3b_control_word;

   typedef struct packed {
      logic             valid;
      lc3b_control_word ctrl;
      lc3b_word         pc;
      lc3b_reg          dest;
      lc3b_word         src1_data;
      lc3b_word         src2_data;
      lc3b_word         imm5;
      lc3b_word         offset6;
      lc3b_word         offset9;
      lc3b_word         offset11;
      lc3b_imm4         imm4;
      lc3b_trapvect8    trapvect8;
      lc3b_nzp          nzp;
      logic             bit4;
   } lc3b_decoded;

endpackage : lc3b_types

`default_nettype wire

// ==== rtl/control_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_rom (
   input  lc3b_types::lc3b_opcode       opcode,
   input  logic [2:0]                   bits4_5_11,  // {bit11, bit5, bit4}
   output lc3b_types::lc3b_control_word ctrl
);

   import lc3b_types::*;

   always_comb begin
      ctrl = '0;
      ctrl.opcode = opcode;
      ctrl.aluop = alu_add;

      case (opcode)
         op_add, op_and: begin
            ctrl.aluop = (opcode == op_and) ? alu_and : alu_add;
            ctrl.alumux_sel = bits4_5_11[1] ? 3'b011 : 3'b000;  // imm5 or sr2
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.valid_dest = 1'b1;
         end

         op_not: begin
            ctrl.aluop = alu_not;
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.valid_dest = 1'b1;
         end

         op_shf: begin
            if (!bits4_5_11[0]) begin
               ctrl.aluop = alu_sll;
            end else if (!bits4_5_11[1]) begin
               ctrl.aluop = alu_srl;
            end else begin
               ctrl.aluop = alu_sra;
            end
            ctrl.alumux_sel = 3'b100;  // imm4 count
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.valid_dest = 1'b1;
         end

         // ldi reads only once here, same as ldr
         op_ldr, op_ldi: begin
            ctrl.alumux_sel = 3'b001;
            ctrl.mem_read = 1'b1;
            ctrl.mdrmux_sel = 2'b01;  // memory data
            ctrl.regfilemux_sel = 2'b01;
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.valid_dest = 1'b1;
         end

         op_ldb: begin
            ctrl.alumux_sel = 3'b001;
            ctrl.offset6mux_sel = 1'b1;  // unscaled offset
            ctrl.mem_read = 1'b1;
            ctrl.mdrmux_sel = 2'b01;
            ctrl.wordinmux_sel = 1'b1;  // zero-extended byte
            ctrl.regfilemux_sel = 2'b01;
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.valid_dest = 1'b1;
         end

         op_str, op_sti: begin
            ctrl.alumux_sel = 3'b001;
            ctrl.mem_write = 1'b1;
            ctrl.storemux_sel = 1'b1;
            ctrl.mdrmux_sel = 2'b00;  // full word
         end

         op_stb: begin
            ctrl.alumux_sel = 3'b001;
            ctrl.offset6mux_sel = 1'b1;
            ctrl.mem_write = 1'b1;
            ctrl.storemux_sel = 1'b1;
            ctrl.mdrmux_sel = 2'b10;  // byte in both halves
         end

         op_lea: begin
            ctrl.alumux_sel = 3'b010;
            ctrl.alubasemux_sel = 1'b1;  // pc + offset9
            ctrl.regfilemux_sel = 2'b00;
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.valid_dest = 1'b1;
         end

         op_br: begin
            ctrl.pcmux_sel = 2'b01;  // resolved against cc in execute
            ctrl.valid_branch = 1'b1;
         end

         op_jmp: begin  // ret too
            ctrl.aluop = alu_pass;
            ctrl.pcmux_sel = 2'b10;
            ctrl.load_pc = 1'b1;
            ctrl.valid_branch = 1'b1;
         end

         op_jsr: begin
            ctrl.regfilemux_sel = 2'b10;  // return pc
            ctrl.load_regfile = 1'b1;
            ctrl.destmux_sel = 1'b1;
            ctrl.load_pc = 1'b1;
            ctrl.valid_branch = 1'b1;
            if (bits4_5_11[2]) begin
               ctrl.offsetmux_sel = 1'b1;
               ctrl.pcmux_sel = 2'b01;
            end else begin
               ctrl.aluop = alu_pass;  // jsrr base
               ctrl.pcmux_sel = 2'b10;
            end
         end

         op_trap: begin
            ctrl.regfilemux_sel = 2'b10;
            ctrl.load_regfile = 1'b1;
            ctrl.destmux_sel = 1'b1;
            ctrl.marmux_sel = 2'b01;  // vector table address
            ctrl.mem_read = 1'b1;
            ctrl.mdrmux_sel = 2'b01;
            ctrl.pcmux_sel = 2'b11;  // target from memory
            ctrl.load_pc = 1'b1;
            ctrl.valid_branch = 1'b1;
         end

         default: begin
            ctrl = '0;
         end
      endcase
   end

endmodule : control_rom

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 load,
   input  lc3b_types::lc3b_reg  dest,
   input  lc3b_types::lc3b_word in,
   input  lc3b_types::lc3b_reg  src_a,
   input  lc3b_types::lc3b_reg  src_b,
   output lc3b_types::lc3b_word reg_a,
   output lc3b_types::lc3b_word reg_b
);

   import lc3b_types::*;

   lc3b_word regs [8];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (load) begin
         regs[dest] <= in;
      end
   end

   // write-through so back-to-back dependents see the new value
   assign reg_a = (load && dest == src_a) ? in : regs[src_a];
   assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule : regfile

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  lc3b_types::lc3b_aluop aluop,
   input  lc3b_types::lc3b_word  a,
   input  lc3b_types::lc3b_word  b,
   output lc3b_types::lc3b_word  f
);

   import lc3b_types::*;

   logic [3:0] shamt;

   assign shamt = b[3:0];  // shifts take the count in b

   always_comb begin
      case (aluop)
         alu_add:  f = a + b;
         alu_and:  f = a & b;
         alu_not:  f = ~a;
         alu_pass: f = a;
         alu_sll:  f = a << shamt;
         alu_srl:  f = a >> shamt;
         alu_sra:  f = lc3b_word'($signed(a) >>> shamt);
         default:  f = a;
      endcase
   end

endmodule : alu

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    instr_valid,
   input  lc3b_types::lc3b_word    instr,
   input  lc3b_types::lc3b_word    instr_pc,
   output lc3b_types::lc3b_reg     src_a,
   output lc3b_types::lc3b_reg     src_b,
   input  lc3b_types::lc3b_word    reg_a,
   input  lc3b_types::lc3b_word    reg_b,
   output lc3b_types::lc3b_decoded dec
);

   import lc3b_types::*;

   lc3b_control_word ctrl;

   control_rom rom_i (
      .opcode     (lc3b_opcode'(instr[15:12])),
      .bits4_5_11 ({instr[11], instr[5], instr[4]}),
      .ctrl       (ctrl)
   );

   assign src_a = instr[8:6];  // sr1 or base
   assign src_b = ctrl.storemux_sel ? instr[11:9] : instr[2:0];  // store data on port b

   always_ff @(posedge clk) begin
      dec.ctrl <= ctrl;
      dec.pc <= instr_pc;
      dec.dest <= instr[11:9];
      dec.src1_data <= reg_a;
      dec.src2_data <= reg_b;
      dec.imm5 <= {{11{instr[4]}}, instr[4:0]};
      dec.offset6 <= {{10{instr[5]}}, instr[5:0]};
      dec.offset9 <= {{7{instr[8]}}, instr[8:0]};
      dec.offset11 <= {{5{instr[10]}}, instr[10:0]};
      dec.imm4 <= instr[3:0];
      dec.trapvect8 <= instr[7:0];
      dec.nzp <= instr[11:9];
      dec.bit4 <= instr[4];
      if (reset) begin
         dec.valid <= 1'b0;
      end else begin
         dec.valid <= instr_valid;  // bubbles pass through
      end
   end

endmodule : decode_stage

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_settings.svh"

module execute_stage (
   input  logic                    clk,
   input  logic                    reset,
   input  lc3b_types::lc3b_decoded dec,
   input  lc3b_types::lc3b_word    mem_rdata,
   output logic                    mem_read,
   output logic                    mem_write,
   output logic                    mem_byte,
   output lc3b_types::lc3b_word    mem_addr,
   output lc3b_types::lc3b_word    mem_wdata,
   output logic                    wb_valid,
   output lc3b_types::lc3b_reg     wb_dest,
   output lc3b_types::lc3b_word    wb_data,
   output lc3b_types::lc3b_nzp     cc,
   output logic                    branch_taken,
   output lc3b_types::lc3b_word    branch_target
);

   import lc3b_types::*;

   lc3b_control_word ctrl;
   lc3b_word         alu_a;
   lc3b_word         alu_b;
   lc3b_word         alu_out;
   lc3b_word         pc_offset;
   lc3b_word         br_add;
   lc3b_word         trap_addr;
   lc3b_word         mdr_data;
   logic [7:0]       load_byte;
   lc3b_nzp          nzp_next;

   assign ctrl = dec.ctrl;

   assign pc_offset = ctrl.offsetmux_sel ? (dec.offset11 << 1) : (dec.offset9 << 1);
   assign br_add = dec.pc + pc_offset;
   assign trap_addr = {8'h00, dec.trapvect8} << `LC3B_TRAP_SHIFT;

   assign alu_a = ctrl.alubasemux_sel ? dec.pc : dec.src1_data;

   always_comb begin
      case (ctrl.alumux_sel)
         3'b001:  alu_b = ctrl.offset6mux_sel ? dec.offset6 : (dec.offset6 << 1);
         3'b010:  alu_b = pc_offset;
         3'b011:  alu_b = dec.imm5;
         3'b100:  alu_b = {12'h000, dec.imm4};
         default: alu_b = dec.src2_data;
      endcase
   end

   alu alu_i (
      .aluop (ctrl.aluop),
      .a     (alu_a),
      .b     (alu_b),
      .f     (alu_out)
   );

   assign mem_addr = (ctrl.marmux_sel == 2'b01) ? trap_addr : alu_out;
   assign mem_read = dec.valid & ctrl.mem_read;
   assign mem_write = dec.valid & ctrl.mem_write;
   assign mem_byte = dec.valid & ctrl.offset6mux_sel;
   assign load_byte = mem_addr[0] ? mem_rdata[15:8] : mem_rdata[7:0];

   always_comb begin
      case (ctrl.mdrmux_sel)
         2'b01:   mdr_data = ctrl.wordinmux_sel ? {8'h00, load_byte} : mem_rdata;
         2'b10:   mdr_data = {2{dec.src2_data[7:0]}};  // byte lane picked by addr[0]
         default: mdr_data = dec.src2_data;
      endcase
   end

   assign mem_wdata = mdr_data;

   always_comb begin
      case (ctrl.regfilemux_sel)
         2'b01:   wb_data = mdr_data;
         2'b10:   wb_data = dec.pc;  // link value
         default: wb_data = alu_out;
      endcase
   end

   assign wb_valid = dec.valid & ctrl.load_regfile;
   assign wb_dest = ctrl.destmux_sel ? lc3b_reg'(`LC3B_LINK_REG) : dec.dest;

   always_comb begin
      case (ctrl.pcmux_sel)
         2'b01:   branch_target = br_add;
         2'b10:   branch_target = alu_out;
         2'b11:   branch_target = mdr_data;  // trap vector contents
         default: branch_target = dec.pc;
      endcase
   end

   // br tests its nzp bits, the others always redirect
   assign branch_taken = dec.valid & ctrl.valid_branch & (ctrl.load_pc | (|(dec.nzp & cc)));

   assign nzp_next = wb_data[15] ? 3'b100 : ((wb_data == '0) ? 3'b010 : 3'b001);

   always_ff @(posedge clk) begin
      if (reset) begin
         cc <= `LC3B_RESET_NZP;
      end else if (dec.valid && ctrl.load_cc) begin
         cc <= nzp_next;
      end
   end

endmodule : execute_stage

`default_nettype wire

// ==== rtl/lc3b_core_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_core_slice (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 instr_valid,
   input  lc3b_types::lc3b_word instr,
   input  lc3b_types::lc3b_word instr_pc,
   input  lc3b_types::lc3b_word mem_rdata,
   output logic                 mem_read,
   output logic                 mem_write,
   output lc3b_types::lc3b_word mem_addr,
   output lc3b_types::lc3b_word mem_wdata,
   output logic                 mem_byte,
   output logic                 wb_valid,
   output lc3b_types::lc3b_reg  wb_dest,
   output lc3b_types::lc3b_word wb_data,
   output lc3b_types::lc3b_nzp  cc,
   output logic                 branch_taken,
   output lc3b_types::lc3b_word branch_target
);

   import lc3b_types::*;

   lc3b_decoded dec;
   lc3b_reg     src_a;
   lc3b_reg     src_b;
   lc3b_word    reg_a;
   lc3b_word    reg_b;

   decode_stage decode_i (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_pc    (instr_pc),
      .src_a       (src_a),
      .src_b       (src_b),
      .reg_a       (reg_a),
      .reg_b       (reg_b),
      .dec         (dec)
   );

   regfile regfile_i (
      .clk   (clk),
      .reset (reset),
      .load  (wb_valid),  // written back from execute
      .dest  (wb_dest),
      .in    (wb_data),
      .src_a (src_a),
      .src_b (src_b),
      .reg_a (reg_a),
      .reg_b (reg_b)
   );

   execute_stage execute_i (
      .clk           (clk),
      .reset         (reset),
      .dec           (dec),
      .mem_rdata     (mem_rdata),
      .mem_read      (mem_read),
      .mem_write     (mem_write),
      .mem_byte      (mem_byte),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .wb_valid      (wb_valid),
      .wb_dest       (wb_dest),
      .wb_data       (wb_data),
      .cc            (cc),
      .branch_taken  (branch_taken),
      .branch_target (branch_target)
   );

endmodule : lc3b_core_slice

`default_nettype wire

// ==== sim/tb_lc3b_core_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_settings.svh"

module tb_lc3b_core_slice;

   import lc3b_types::*;

   typedef struct packed {
      logic     valid;
      lc3b_word instr;
      lc3b_word pc;
      lc3b_word rdata;      // memory response during execute
      logic     mem_read;
      logic     mem_write;
      logic     mem_byte;
      lc3b_word mem_addr;
      lc3b_word mem_wdata;
      logic     wb_valid;
      lc3b_reg  wb_dest;
      lc3b_word wb_data;
      logic     taken;
      lc3b_word target;
      lc3b_nzp  cc;         // flags after the row retires
   } table_row_t;

   logic     clk = 1'b0;
   logic     reset;
   logic     instr_valid;
   lc3b_word instr;
   lc3b_word instr_pc;
   lc3b_word mem_rdata;
   logic     mem_read;
   logic     mem_write;
   lc3b_word mem_addr;
   lc3b_word mem_wdata;
   logic     mem_byte;
   logic     wb_valid;
   lc3b_reg  wb_dest;
   lc3b_word wb_data;
   lc3b_nzp  cc;
   logic     branch_taken;
   lc3b_word branch_target;

   table_row_t rows[$];
   int         cycle_count = 0;
   int         cycle_limit = 0;

   lc3b_core_slice dut_i (
      .clk           (clk),
      .reset         (reset),
      .instr_valid   (instr_valid),
      .instr         (instr),
      .instr_pc      (instr_pc),
      .mem_rdata     (mem_rdata),
      .mem_read      (mem_read),
      .mem_write     (mem_write),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .mem_byte      (mem_byte),
      .wb_valid      (wb_valid),
      .wb_dest       (wb_dest),
      .wb_data       (wb_data),
      .cc            (cc),
      .branch_taken  (branch_taken),
      .branch_target (branch_target)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("run did not finish within %0d cycles", cycle_limit);
         $display("Verification failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
      if (got !== expected) begin
         $display("MISMATCH at %0t: %s got 0x%04h expected 0x%04h", $time, name, got, expected);
         $display("Verification failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // incremented pc of each row follows the table position
   function automatic table_row_t blank_row(input lc3b_word ins);
      table_row_t r;
      r = '0;
      r.valid = 1'b1;
      r.instr = ins;
      r.pc = 16'h3002 + 16'(2 * rows.size());
      return r;
   endfunction

   task automatic alu_row(input lc3b_word ins, input lc3b_reg dest, input lc3b_word data,
                          input lc3b_nzp cc_exp);
      table_row_t r;
      r = blank_row(ins);
      r.wb_valid = 1'b1;
      r.wb_dest = dest;
      r.wb_data = data;
      r.cc = cc_exp;
      rows.push_back(r);
   endtask

   task automatic load_row(input lc3b_word ins, input lc3b_word rdata, input lc3b_word addr,
                           input logic byte_acc, input lc3b_reg dest, input lc3b_word data,
                           input lc3b_nzp cc_exp);
      table_row_t r;
      r = blank_row(ins);
      r.rdata = rdata;
      r.mem_read = 1'b1;
      r.mem_byte = byte_acc;
      r.mem_addr = addr;
      r.wb_valid = 1'b1;
      r.wb_dest = dest;
      r.wb_data = data;
      r.cc = cc_exp;
      rows.push_back(r);
   endtask

   task automatic store_row(input lc3b_word ins, input lc3b_word addr, input logic byte_acc,
                            input lc3b_word wdata, input lc3b_nzp cc_exp);
      table_row_t r;
      r = blank_row(ins);
      r.mem_write = 1'b1;
      r.mem_byte = byte_acc;
      r.mem_addr = addr;
      r.mem_wdata = wdata;
      r.cc = cc_exp;
      rows.push_back(r);
   endtask

   task automatic jump_row(input lc3b_word ins, input logic link, input logic taken,
                           input lc3b_word target, input lc3b_nzp cc_exp);
      table_row_t r;
      r = blank_row(ins);
      r.wb_valid = link;
      r.wb_dest = `LC3B_LINK_REG;
      r.wb_data = r.pc;  // return address
      r.taken = taken;
      r.target = target;
      r.cc = cc_exp;
      rows.push_back(r);
   endtask

   task automatic trap_row(input lc3b_word ins, input lc3b_word rdata, input lc3b_word addr,
                           input lc3b_nzp cc_exp);
      table_row_t r;
      r = blank_row(ins);
      r.rdata = rdata;
      r.mem_read = 1'b1;
      r.mem_addr = addr;
      r.wb_valid = 1'b1;
      r.wb_dest = `LC3B_LINK_REG;
      r.wb_data = r.pc;
      r.taken = 1'b1;
      r.target = rdata;  // vector table entry
      r.cc = cc_exp;
      rows.push_back(r);
   endtask

   task automatic idle_row(input lc3b_word ins, input lc3b_nzp cc_exp);
      table_row_t r;
      r = blank_row(ins);
      r.valid = 1'b0;
      r.cc = cc_exp;
      rows.push_back(r);
   endtask

   task automatic check_outputs(input table_row_t r);
      check_value("mem_read", 16'(mem_read), 16'(r.mem_read));
      check_value("mem_write", 16'(mem_write), 16'(r.mem_write));
      check_value("mem_byte", 16'(mem_byte), 16'(r.mem_byte));
      check_value("wb_valid", 16'(wb_valid), 16'(r.wb_valid));
      check_value("branch_taken", 16'(branch_taken), 16'(r.taken));
      if (r.mem_read || r.mem_write) begin
         check_value("mem_addr", mem_addr, r.mem_addr);
      end
      if (r.mem_write) begin
         check_value("mem_wdata", mem_wdata, r.mem_wdata);
      end
      if (r.wb_valid) begin
         check_value("wb_dest", 16'(wb_dest), 16'(r.wb_dest));
         check_value("wb_data", wb_data, r.wb_data);
      end
      if (r.taken) begin
         check_value("branch_target", branch_target, r.target);
      end
   endtask

   task automatic build_table();
      alu_row(16'h1225, 3'd1, 16'h0005, 3'b001);  // add r1, r0, #5
      alu_row(16'h1479, 3'd2, 16'hFFFE, 3'b100);  // add r2, r1, #-7 via bypass
      alu_row(16'h5642, 3'd3, 16'h0004, 3'b001);  // and r3, r1, r2
      alu_row(16'h58E0, 3'd4, 16'h0000, 3'b010);  // and r4, r3, #0
      alu_row(16'h1A42, 3'd5, 16'h0003, 3'b001);  // add r5, r1, r2
      alu_row(16'h9CFF, 3'd6, 16'hFFFB, 3'b100);  // not r6, r3
      alu_row(16'hD843, 3'd4, 16'h0028, 3'b001);  // lshf r4, r1, #3
      alu_row(16'hDB92, 3'd5, 16'h3FFE, 3'b001);  // rshfl r5, r6, #2
      alu_row(16'hDFB2, 3'd7, 16'hFFFE, 3'b100);  // rshfa r7, r6, #2
      idle_row(16'h1021, 3'b100);                 // bubble
      load_row(16'h6303, 16'h8001, 16'h002E, 1'b0, 3'd1, 16'h8001, 3'b100);  // ldr r1, r4, #3
      load_row(16'h2505, 16'hA57E, 16'h002D, 1'b1, 3'd2, 16'h00A5, 3'b001);  // ldb, high byte
      load_row(16'hA77F, 16'h0000, 16'h3FFC, 1'b0, 3'd3, 16'h0000, 3'b010);  // ldi r3, r5, #-1
      alu_row(16'hE004, 3'd0, 16'h3024, 3'b001);  // lea r0, #4
      store_row(16'h733E, 16'h0024, 1'b0, 16'h8001, 3'b001);  // str r1, r4, #-2
      store_row(16'h3401, 16'h3025, 1'b1, 16'hA5A5, 3'b001);  // stb r2, r0, #1
      store_row(16'hBD41, 16'h4000, 1'b0, 16'hFFFB, 3'b001);  // sti r6, r5, #1
      jump_row(16'h080A, 1'b0, 1'b0, 16'h0000, 3'b001);  // brn not taken
      jump_row(16'h03FD, 1'b0, 1'b1, 16'h3020, 3'b001);  // brp #-3
      jump_row(16'hC000, 1'b0, 1'b1, 16'h3024, 3'b001);  // jmp r0
      jump_row(16'h4810, 1'b1, 1'b1, 16'h304A, 3'b001);  // jsr #16
      jump_row(16'h4100, 1'b1, 1'b1, 16'h0028, 3'b001);  // jsrr r4
      trap_row(16'hF025, 16'h1234, 16'h004A, 3'b001);    // trap x25
      alu_row(16'h17E0, 3'd3, 16'h302E, 3'b001);  // add r3, r7, #0
      alu_row(16'h56E0, 3'd3, 16'h0000, 3'b010);  // and r3, r3, #0
      jump_row(16'h0401, 1'b0, 1'b1, 16'h3036, 3'b010);  // brz #1
      jump_row(16'h0A01, 1'b0, 1'b0, 16'h0000, 3'b010);  // brnp not taken
      idle_row(16'hC000, 3'b010);                         // jmp held off by valid
   endtask

   initial begin
      int n;
      reset <= 1'b1;
      instr_valid <= 1'b0;
      instr <= '0;
      instr_pc <= '0;
      mem_rdata <= '0;
      build_table();
      n = rows.size();
      cycle_limit = n + 40;

      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("wb_valid", 16'(wb_valid), 16'h0000);
      check_value("mem_read", 16'(mem_read), 16'h0000);
      check_value("mem_write", 16'(mem_write), 16'h0000);
      check_value("mem_byte", 16'(mem_byte), 16'h0000);
      check_value("branch_taken", 16'(branch_taken), 16'h0000);
      check_value("cc", 16'(cc), 16'(`LC3B_RESET_NZP));

      // row i enters decode, row i-1 executes, row i-2 has updated cc
      for (int i = 0; i < n + 2; i++) begin
         @(posedge clk);
         if (i < n) begin
            instr_valid <= rows[i].valid;
            instr <= rows[i].instr;
            instr_pc <= rows[i].pc;
         end else begin
            instr_valid <= 1'b0;
         end
         if (i >= 1 && i - 1 < n) begin
            mem_rdata <= rows[i - 1].rdata;
         end else begin
            mem_rdata <= '0;
         end
         @(negedge clk);
         if (i >= 1 && i - 1 < n) begin
            check_outputs(rows[i - 1]);
         end
         if (i >= 2) begin
            check_value("cc", 16'(cc), 16'(rows[i - 2].cc));
         end
      end

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+rtl
rtl/lc3b_types.sv
rtl/control_rom.sv
rtl/regfile.sv
rtl/alu.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/lc3b_core_slice.sv
sim/tb_lc3b_core_slice.sv

// ==== Makefile ====
TOP = tb_lc3b_core_slice
SRCS = $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

obj_dir/V$(TOP): files.f $(SRCS)
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f

lint:
	verilator --lint-only --timing --top-module lc3b_core_slice -f files.f

clean:
	rm -rf obj_dir
